// ==== rtl/vec_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the vector coprocessor: element and register index
// types, the core opcodes and the request broadcast to the lanes.
// Imported with a wildcard by every RTL module.
////////////////////////////////////////////////////////////////////////////

package vec_pkg;

  // Element width, one word
  localparam int unsigned ElemWidth = 16;
  typedef logic [ElemWidth-1:0] elen_t;

  // Architectural vector registers
  localparam int unsigned NrVRegs = 8;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  // Opcodes seen on the core interface
  typedef enum logic [2:0] {
    OP_VID_VX    = 3'd0,
    OP_ADD_VV    = 3'd1,
    OP_ADD_VX    = 3'd2,
    OP_AND_VV    = 3'd3,
    OP_XOR_VV    = 3'd4,
    OP_XOR_VX    = 3'd5,
    OP_REDSUM_VS = 3'd6,
    OP_MV_XS     = 3'd7
  } vec_op_e;

  // Lane ALU operations
  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_AND = 2'd1,
    ALU_XOR = 2'd2,
    ALU_IDX = 2'd3
  } alu_op_e;

  // Decoded request, broadcast to all processing elements
  typedef struct packed {
    alu_op_e   alu_op;
    logic      use_scalar;
    logic      write_vd;
    logic      reduce;
    logic      extract;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elen_t     scalar;
    // Clamped vector length, zero for extracts
    elen_t     vl;
  } lane_req_t;

endpackage : vec_pkg

// ==== rtl/vec_dispatcher.sv ====
////////////////////////////////////////////////////////////////////////////
// Core-side front end. Runs the four-phase req/ack handshake, decodes
// the opcode into a lane request and holds the scalar response until
// the core drops its request.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_dispatcher import vec_pkg::*; #(
  parameter  int unsigned VlMax   = 16,
  localparam int unsigned VlWidth = $clog2(VlMax + 1)
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Core handshake
  input  logic               req_i,
  input  vec_op_e            op_i,
  input  vreg_idx_t          vd_i,
  input  vreg_idx_t          vs1_i,
  input  vreg_idx_t          vs2_i,
  input  elen_t              scalar_i,
  input  logic [VlWidth-1:0] vl_i,
  output logic               ack_o,
  output elen_t              result_o,
  // Sequencer side
  output logic               issue_o,
  output lane_req_t          lane_req_o,
  input  logic               done_i,
  input  elen_t              result_i
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    ACKED
  } state_e;

  state_e             state_q;
  logic               issue_q;
  elen_t              result_q;
  lane_req_t          lane_req_q;
  lane_req_t          req_d;
  logic [VlWidth-1:0] vl_clamp;

  //////////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    vl_clamp = (vl_i > VlWidth'(VlMax)) ? VlWidth'(VlMax) : vl_i;

    req_d        = '0;
    req_d.vd     = vd_i;
    req_d.vs1    = vs1_i;
    req_d.vs2    = vs2_i;
    req_d.scalar = scalar_i;
    req_d.vl     = elen_t'(vl_clamp);

    case (op_i)
      OP_VID_VX: begin
        req_d.alu_op     = ALU_IDX;
        req_d.use_scalar = 1'b1;
        req_d.write_vd   = 1'b1;
      end
      OP_ADD_VV: begin
        req_d.alu_op   = ALU_ADD;
        req_d.write_vd = 1'b1;
      end
      OP_ADD_VX: begin
        req_d.alu_op     = ALU_ADD;
        req_d.use_scalar = 1'b1;
        req_d.write_vd   = 1'b1;
      end
      OP_AND_VV: begin
        req_d.alu_op   = ALU_AND;
        req_d.write_vd = 1'b1;
      end
      OP_XOR_VV: begin
        req_d.alu_op   = ALU_XOR;
        req_d.write_vd = 1'b1;
      end
      OP_XOR_VX: begin
        req_d.alu_op     = ALU_XOR;
        req_d.use_scalar = 1'b1;
        req_d.write_vd   = 1'b1;
      end
      OP_REDSUM_VS: begin
        req_d.reduce = 1'b1;
      end
      default: begin
        // Scalar move, the element index wraps at VlMax and no row is stepped
        req_d.extract = 1'b1;
        req_d.scalar  = elen_t'(32'(scalar_i) % VlMax);
        req_d.vl      = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      issue_q  <= 1'b0;
      result_q <= '0;
    end else begin
      issue_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (req_i) begin
            issue_q <= 1'b1;
            state_q <= BUSY;
          end
        end
        BUSY: begin
          if (done_i) begin
            result_q <= result_i;
            state_q  <= ACKED;
          end
        end
        default: begin
          // Hold ack until the core lets go
          if (!req_i) state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) lane_req_q <= req_d;
  end

  assign ack_o      = (state_q == ACKED);
  assign result_o   = result_q;
  assign issue_o    = issue_q;
  assign lane_req_o = lane_req_q;

endmodule : vec_dispatcher

// ==== rtl/vec_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Broadcasts one decoded request to the lanes and the reduction unit,
// then waits for the reduction unit, which in turn waits for every lane.
// One instruction is in flight at a time.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_sequencer import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Dispatcher side
  input  logic      issue_i,
  input  lane_req_t lane_req_i,
  output logic      done_o,
  output elen_t     result_o,
  // Processing elements
  output logic      pe_req_valid_o,
  output lane_req_t pe_req_o,
  input  logic      red_done_i,
  input  elen_t     red_result_i
);

  logic      pe_req_valid_q;
  lane_req_t pe_req_q;
  logic      busy_q;
  logic      done_q;
  elen_t     result_q;

  //////////////////////////////////////////////////////////////////////////
  // Broadcast and completion tracking
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pe_req_valid_q <= 1'b0;
      busy_q         <= 1'b0;
      done_q         <= 1'b0;
    end else begin
      // One-cycle broadcast pulse
      pe_req_valid_q <= issue_i;
      done_q         <= busy_q & red_done_i;
      if (issue_i) begin
        busy_q <= 1'b1;
      end else if (red_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Request and result payload
  always_ff @(posedge clk_i) begin
    if (issue_i) pe_req_q <= lane_req_i;
    if (busy_q && red_done_i) result_q <= red_result_i;
  end

  assign pe_req_valid_o = pe_req_valid_q;
  assign pe_req_o       = pe_req_q;
  assign done_o         = done_q;
  assign result_o       = result_q;

endmodule : vec_sequencer

// ==== rtl/vec_lane.sv ====
////////////////////////////////////////////////////////////////////////////
// One vector lane. Holds elements LaneId, LaneId + NrLanes, ... of every
// register and steps one row per cycle through the ALU. The lane partial
// carries the vs2 sum for reductions or the element for a scalar move.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_lane import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VlMax   = 16,
  parameter int unsigned LaneId  = 0
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      pe_req_valid_i,
  input  lane_req_t pe_req_i,
  output logic      done_o,
  output elen_t     partial_o
);

  localparam int unsigned NrRows = VlMax / NrLanes;
  localparam int unsigned RowW   = (NrRows > 1) ? $clog2(NrRows) : 1;

  // Register file slice
  elen_t           vrf_q [NrVRegs][NrRows];

  lane_req_t       req_q;
  logic            busy_q;
  logic            done_q;
  logic [RowW-1:0] row_q;
  elen_t           partial_q;

  elen_t           op_a;
  elen_t           op_b;
  elen_t           alu_res;
  elen_t           elem_idx;
  logic [31:0]     next_idx;
  logic            last_row;
  logic            xt_hit;
  logic [RowW-1:0] xt_row;

  //////////////////////////////////////////////////////////////////////////
  // Operands and ALU
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    elem_idx = elen_t'(32'(row_q) * NrLanes + LaneId);
    op_a     = req_q.use_scalar ? req_q.scalar : vrf_q[req_q.vs1][row_q];
    op_b     = vrf_q[req_q.vs2][row_q];
    case (req_q.alu_op)
      ALU_ADD: alu_res = op_a + op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      default: alu_res = req_q.scalar + elem_idx;
    endcase

    // Stop after the last row below vl
    next_idx = (32'(row_q) + 32'd1) * NrLanes + LaneId;
    last_row = (32'(row_q) == NrRows - 1) || (next_idx >= 32'(req_q.vl));

    // Scalar move lookup, scalar already wrapped to VlMax
    xt_hit = (32'(pe_req_i.scalar) % NrLanes) == LaneId;
    xt_row = RowW'(32'(pe_req_i.scalar) / NrLanes);
  end

  //////////////////////////////////////////////////////////////////////////
  // Row stepping
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      row_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (pe_req_valid_i) begin
        row_q <= '0;
        // Lane owns row 0 only if its first element is below vl
        if (LaneId < 32'(pe_req_i.vl)) begin
          busy_q <= 1'b1;
        end else begin
          done_q <= 1'b1;
        end
      end else if (busy_q) begin
        if (last_row) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
    end
  end

  // Registers come up as zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vrf_q <= '{default: '0};
    end else if (busy_q && req_q.write_vd) begin
      vrf_q[req_q.vd][row_q] <= alu_res;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      req_q     <= pe_req_i;
      partial_q <= (pe_req_i.extract && xt_hit) ? vrf_q[pe_req_i.vs2][xt_row] : '0;
    end else if (busy_q && req_q.reduce) begin
      partial_q <= partial_q + op_b;
    end
  end

  assign done_o    = done_q;
  assign partial_o = partial_q;

endmodule : vec_lane

// ==== rtl/vec_reduce.sv ====
////////////////////////////////////////////////////////////////////////////
// Cross-lane reduction. Waits until every lane has reported done, then
// adds all lane partials to the seed (the scalar for a sum reduction,
// zero otherwise) and returns the scalar answer.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_reduce import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      pe_req_valid_i,
  input  lane_req_t                 pe_req_i,
  input  logic       [NrLanes-1:0]  lane_done_i,
  input  elen_t      [NrLanes-1:0]  lane_partial_i,
  output logic                      done_o,
  output elen_t                     result_o
);

  logic [NrLanes-1:0] seen_q;
  logic               active_q;
  logic               done_q;
  elen_t              seed_q;
  elen_t              result_q;
  elen_t              sum;
  logic               all_done;

  always_comb begin
    all_done = &(seen_q | lane_done_i);
    sum      = seed_q;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      sum = sum + lane_partial_i[l];
    end
  end

  // Sticky per-lane done bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seen_q   <= '0;
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (pe_req_valid_i) begin
        seen_q   <= '0;
        active_q <= 1'b1;
      end else if (active_q) begin
        seen_q <= seen_q | lane_done_i;
        if (all_done) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) seed_q <= pe_req_i.reduce ? pe_req_i.scalar : '0;
    if (active_q && all_done) result_q <= sum;
  end

  assign done_o   = done_q;
  assign result_o = result_q;

endmodule : vec_reduce

// ==== rtl/vec_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Vector coprocessor top level. Connects the dispatcher, the sequencer,
// NrLanes lanes and the reduction unit. The core talks to it through a
// four-phase req/ack handshake.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_top import vec_pkg::*; #(
  parameter  int unsigned NrLanes = 4,
  parameter  int unsigned VlMax   = 16,
  localparam int unsigned VlWidth = $clog2(VlMax + 1)
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Core interface
  input  logic               req_i,
  input  vec_op_e            op_i,
  input  vreg_idx_t          vd_i,
  input  vreg_idx_t          vs1_i,
  input  vreg_idx_t          vs2_i,
  input  elen_t              scalar_i,
  input  logic [VlWidth-1:0] vl_i,
  output logic               ack_o,
  output elen_t              result_o
);

  // Dispatcher to sequencer
  logic                        issue;
  lane_req_t                   lane_req;
  logic                        seq_done;
  elen_t                       seq_result;
  // Sequencer to processing elements
  logic                        pe_req_valid;
  lane_req_t                   pe_req;
  logic         [NrLanes-1:0]  lane_done;
  elen_t        [NrLanes-1:0]  lane_partial;
  logic                        red_done;
  elen_t                       red_result;

  vec_dispatcher #(
    .VlMax(VlMax)
  ) i_dispatcher (
    .clk_i     (clk_i     ),
    .arst_n_i  (arst_n_i  ),
    .req_i     (req_i     ),
    .op_i      (op_i      ),
    .vd_i      (vd_i      ),
    .vs1_i     (vs1_i     ),
    .vs2_i     (vs2_i     ),
    .scalar_i  (scalar_i  ),
    .vl_i      (vl_i      ),
    .ack_o     (ack_o     ),
    .result_o  (result_o  ),
    .issue_o   (issue     ),
    .lane_req_o(lane_req  ),
    .done_i    (seq_done  ),
    .result_i  (seq_result)
  );

  vec_sequencer i_sequencer (
    .clk_i         (clk_i       ),
    .arst_n_i      (arst_n_i    ),
    .issue_i       (issue       ),
    .lane_req_i    (lane_req    ),
    .done_o        (seq_done    ),
    .result_o      (seq_result  ),
    .pe_req_valid_o(pe_req_valid),
    .pe_req_o      (pe_req      ),
    .red_done_i    (red_done    ),
    .red_result_i  (red_result  )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes(NrLanes),
      .VlMax  (VlMax  ),
      .LaneId (l      )
    ) i_lane (
      .clk_i         (clk_i          ),
      .arst_n_i      (arst_n_i       ),
      .pe_req_valid_i(pe_req_valid   ),
      .pe_req_i      (pe_req         ),
      .done_o        (lane_done[l]   ),
      .partial_o     (lane_partial[l])
    );
  end : gen_lanes

  vec_reduce #(
    .NrLanes(NrLanes)
  ) i_reduce (
    .clk_i         (clk_i       ),
    .arst_n_i      (arst_n_i    ),
    .pe_req_valid_i(pe_req_valid),
    .pe_req_i      (pe_req      ),
    .lane_done_i   (lane_done   ),
    .lane_partial_i(lane_partial),
    .done_o        (red_done    ),
    .result_o      (red_result  )
  );

endmodule : vec_top

// ==== dv/vec_clk_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset source. Free-running clock, active-low
// reset released on a falling edge after the reset cycles.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_clk_gen #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    #(PeriodNs * ResetCycles);
    arst_n_o = 1'b1;
  end

endmodule : vec_clk_gen

// ==== dv/vec_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the vector coprocessor. Drives a pseudo-random instruction
// stream through the four-phase core handshake and checks every scalar
// response and register element against a model of the register file.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_tb import vec_pkg::*; ();

  localparam int unsigned VlMax      = 16;
  localparam int unsigned VlWidth    = $clog2(VlMax + 1);
  localparam int unsigned AckTimeout = VlMax + 20;

  // Length of the instruction stream
  localparam int unsigned NrRandOps = 40;
  localparam int unsigned NrRedOps  = 24;
  localparam int unsigned NrMixOps  = 80;
  localparam int unsigned NrInstr   = 2 * NrVRegs * VlMax + NrVRegs * (VlMax + 1)
                                    + NrRandOps * (VlMax + 1) + NrRedOps + NrMixOps;
  localparam int unsigned WatchdogCycles = NrInstr * (VlMax + 20) + 10;

  logic               clk;
  logic               arst_n;
  logic               core_req;
  vec_op_e            core_op;
  vreg_idx_t          core_vd;
  vreg_idx_t          core_vs1;
  vreg_idx_t          core_vs2;
  elen_t              core_scalar;
  logic [VlWidth-1:0] core_vl;
  logic               core_ack;
  elen_t              core_result;

  // Reference register file and random state
  elen_t              model_vrf [NrVRegs][VlMax];
  logic [15:0]        lfsr_state;

  // Handshake monitor history
  logic               ack_prev;
  logic               req_prev;
  elen_t              result_prev;

  vec_clk_gen i_clk_gen (
    .clk_o   (clk   ),
    .arst_n_o(arst_n)
  );

  vec_top DUT (
    .clk_i   (clk        ),
    .arst_n_i(arst_n     ),
    .req_i   (core_req   ),
    .op_i    (core_op    ),
    .vd_i    (core_vd    ),
    .vs1_i   (core_vs1   ),
    .vs2_i   (core_vs2   ),
    .scalar_i(core_scalar),
    .vl_i    (core_vl    ),
    .ack_o   (core_ack   ),
    .result_o(core_result)
  );

  //////////////////////////////////////////////////////////////////////////
  // Random numbers and reporting
  //////////////////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;
    return n;
  endfunction

  function automatic logic [15:0] rand_bits(input int unsigned count);
    logic [15:0] v;
    v = '0;
    for (int unsigned b = 0; b < count; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input elen_t expected, input elen_t actual);
    assert (actual === expected) else begin
      $display("[FAIL] %0t ns %s: expected 0x%04h, actual 0x%04h",
               $time, name, expected, actual);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////////

  // Updates the model registers, returns the expected scalar result
  function automatic elen_t model_exec(input vec_op_e op, input vreg_idx_t vd,
                                       input vreg_idx_t vs1, input vreg_idx_t vs2,
                                       input elen_t scalar, input logic [VlWidth-1:0] vl);
    int unsigned vlc;
    int unsigned k;
    elen_t       res;
    vlc = (32'(vl) > VlMax) ? VlMax : 32'(vl);
    k   = 32'(scalar) % VlMax;
    res = '0;
    for (int unsigned i = 0; i < vlc; i++) begin
      case (op)
        OP_VID_VX:    model_vrf[vd][i] = scalar + elen_t'(i);
        OP_ADD_VV:    model_vrf[vd][i] = model_vrf[vs1][i] + model_vrf[vs2][i];
        OP_ADD_VX:    model_vrf[vd][i] = model_vrf[vs2][i] + scalar;
        OP_AND_VV:    model_vrf[vd][i] = model_vrf[vs1][i] & model_vrf[vs2][i];
        OP_XOR_VV:    model_vrf[vd][i] = model_vrf[vs1][i] ^ model_vrf[vs2][i];
        OP_XOR_VX:    model_vrf[vd][i] = model_vrf[vs2][i] ^ scalar;
        OP_REDSUM_VS: res = res + model_vrf[vs2][i];
        default:      res = res;
      endcase
    end
    if (op == OP_REDSUM_VS) res = res + scalar;
    if (op == OP_MV_XS) res = model_vrf[vs2][k];
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Core-side driver
  //////////////////////////////////////////////////////////////////////////

  // Full four-phase transfer with random idle gap and random release delay
  task automatic run_instr(input vec_op_e op, input vreg_idx_t vd, input vreg_idx_t vs1,
                           input vreg_idx_t vs2, input elen_t scalar,
                           input logic [VlWidth-1:0] vl, output elen_t res);
    int unsigned gap;
    int unsigned hold;
    int unsigned waited;
    gap  = 32'(rand_bits(2));
    hold = 32'(rand_bits(2));
    repeat (gap) @(posedge clk);
    @(posedge clk);
    core_req    <= 1'b1;
    core_op     <= op;
    core_vd     <= vd;
    core_vs1    <= vs1;
    core_vs2    <= vs2;
    core_scalar <= scalar;
    core_vl     <= vl;
    waited = 0;
    @(negedge clk);
    while (!core_ack) begin
      assert (waited < AckTimeout) else begin
        $display("%0t ns: no ack_o from the DUT after %0d cycles", $time, waited);
        abort_run();
      end
      waited++;
      @(negedge clk);
    end
    res = core_result;
    repeat (hold) @(posedge clk);
    @(posedge clk);
    core_req <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (core_ack) begin
      assert (waited < AckTimeout) else begin
        $display("%0t ns: ack_o stays high after req_i was released", $time);
        abort_run();
      end
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic execute_and_check(input vec_op_e op, input vreg_idx_t vd,
                                   input vreg_idx_t vs1, input vreg_idx_t vs2,
                                   input elen_t scalar, input logic [VlWidth-1:0] vl);
    elen_t expected;
    elen_t actual;
    expected = model_exec(op, vd, vs1, vs2, scalar, vl);
    run_instr(op, vd, vs1, vs2, scalar, vl, actual);
    check_value("result_o", expected, actual);
  endtask

  // Scalar move with a random multiple of VlMax on top of the index
  task automatic read_element(input vreg_idx_t r, input int unsigned i);
    elen_t scalar;
    scalar = elen_t'(i + VlMax * 32'(rand_bits(8)));
    execute_and_check(OP_MV_XS, vreg_idx_t'(rand_bits(3)), vreg_idx_t'(rand_bits(3)), r,
                      scalar, VlWidth'(rand_bits(VlWidth)));
  endtask

  task automatic read_register(input vreg_idx_t r);
    for (int unsigned i = 0; i < VlMax; i++) begin
      read_element(r, i);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Handshake monitor and watchdog
  //////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (arst_n) begin
      if (core_ack && !ack_prev) begin
        assert (core_req) else begin
          $display("%0t ns: ack_o rose while req_i was low", $time);
          abort_run();
        end
      end
      if (ack_prev && req_prev) begin
        assert (core_ack) else begin
          $display("%0t ns: ack_o fell before req_i was released", $time);
          abort_run();
        end
      end
      if (ack_prev && !req_prev) begin
        assert (!core_ack) else begin
          $display("%0t ns: ack_o did not fall one cycle after req_i fell", $time);
          abort_run();
        end
      end
      if (ack_prev && core_ack) check_value("result_o", result_prev, core_result);
    end
    ack_prev    = core_ack;
    req_prev    = core_req;
    result_prev = core_result;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog: the run did not finish within %0d cycles", WatchdogCycles);
    abort_run();
  end

  //////////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    vec_op_e            op;
    vreg_idx_t          vd;
    vreg_idx_t          vs1;
    vreg_idx_t          vs2;
    elen_t              scalar;
    logic [VlWidth-1:0] vl;
    logic [15:0]        bits;
    int unsigned        sel;
    core_req    = 1'b0;
    core_op     = OP_VID_VX;
    core_vd     = '0;
    core_vs1    = '0;
    core_vs2    = '0;
    core_scalar = '0;
    core_vl     = '0;
    ack_prev    = 1'b0;
    req_prev    = 1'b0;
    result_prev = '0;
    lfsr_state  = 16'd35;
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      for (int unsigned i = 0; i < VlMax; i++) begin
        model_vrf[r][i] = '0;
      end
    end

    // Reset values, during and right after reset
    @(negedge clk);
    check_value("ack_o", '0, elen_t'(core_ack));
    check_value("result_o", '0, core_result);
    @(posedge arst_n);
    @(negedge clk);
    check_value("ack_o", '0, elen_t'(core_ack));
    check_value("result_o", '0, core_result);

    // All registers read back as zero
    for (int unsigned r = 0; r < NrVRegs; r++) read_register(vreg_idx_t'(r));

    // Index splat over the full length of every register
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      scalar = rand_bits(16);
      execute_and_check(OP_VID_VX, vreg_idx_t'(r), '0, '0, scalar, VlWidth'(VlMax));
      read_register(vreg_idx_t'(r));
    end

    // Element-wise ops, first two with zero and oversized vl
    for (int unsigned n = 0; n < NrRandOps; n++) begin
      sel = 32'(rand_bits(3)) % 5;
      case (sel)
        0:       op = OP_ADD_VV;
        1:       op = OP_ADD_VX;
        2:       op = OP_AND_VV;
        3:       op = OP_XOR_VV;
        default: op = OP_XOR_VX;
      endcase
      vd     = vreg_idx_t'(rand_bits(3));
      vs1    = vreg_idx_t'(rand_bits(3));
      vs2    = vreg_idx_t'(rand_bits(3));
      scalar = rand_bits(16);
      vl     = VlWidth'(rand_bits(VlWidth));
      if (n == 0) vl = '0;
      if (n == 1) vl = '1;
      execute_and_check(op, vd, vs1, vs2, scalar, vl);
      read_register(vd);
    end

    // Sum reductions
    for (int unsigned n = 0; n < NrRedOps; n++) begin
      vs2    = vreg_idx_t'(rand_bits(3));
      scalar = rand_bits(16);
      vl     = (n == 0) ? '0 : VlWidth'(rand_bits(VlWidth));
      execute_and_check(OP_REDSUM_VS, vreg_idx_t'(rand_bits(3)), '0, vs2, scalar, vl);
    end

    // Mixed stream of every opcode
    for (int unsigned n = 0; n < NrMixOps; n++) begin
      bits   = rand_bits(3);
      op     = vec_op_e'(bits[2:0]);
      vd     = vreg_idx_t'(rand_bits(3));
      vs1    = vreg_idx_t'(rand_bits(3));
      vs2    = vreg_idx_t'(rand_bits(3));
      scalar = rand_bits(16);
      vl     = VlWidth'(rand_bits(VlWidth));
      execute_and_check(op, vd, vs1, vs2, scalar, vl);
    end

    // Final sweep of the whole register file
    for (int unsigned r = 0; r < NrVRegs; r++) read_register(vreg_idx_t'(r));

    $display("Done: no errors");
    $finish;
  end

endmodule : vec_tb

// ==== filelist.f ====
rtl/vec_pkg.sv
rtl/vec_dispatcher.sv
rtl/vec_sequencer.sv
rtl/vec_lane.sv
rtl/vec_reduce.sv
rtl/vec_top.sv
dv/vec_clk_gen.sv
dv/vec_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the vector coprocessor

VERILATOR  ?= verilator
TOP        := vec_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the testbench printed the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
